/* mips_ex.f */
+incdir+verif
hw/ex_pkg.sv
hw/div_if.sv
hw/divider.sv
hw/alu.sv
hw/hilo_regs.sv
hw/mips_ex.sv
verif/tb_mips_ex.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the mips_ex testbench with verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

log_file=sim.log

verilator --binary --timing --assert \
    -f mips_ex.f \
    --top-module tb_mips_ex \
    -o tb_mips_ex_sim

./obj_dir/tb_mips_ex_sim | tee "$log_file"

if grep -q "^ALL CHECKS PASSED$" "$log_file"; then
    echo "run_sim: simulation passed"
else
    echo "run_sim: simulation failed, see $log_file"
    exit 1
fi

/* verif/tb_tasks.svh */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// expected single-cycle result.
function automatic logic [word_w-1:0] ref_alu(alu_sel_e sel, logic [word_w-1:0] a,
                                               logic [word_w-1:0] b);
    case (sel)
        alu_add:  return a + b;
        alu_sub:  return a - b;
        alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        alu_sltu: return (a < b) ? 32'd1 : 32'd0;
        alu_and:  return a & b;
        alu_nor:  return ~(a | b);
        alu_or:   return a | b;
        alu_xor:  return a ^ b;
        alu_sll:  return a << b[4:0];
        alu_sra:  return $signed(a) >>> b[4:0];
        alu_srl:  return a >> b[4:0];
        alu_lui:  return {b[15:0], 16'h0000};
        default:  return '0;
    endcase
endfunction

function automatic logic [2*word_w-1:0] ref_mult(logic signed_op, logic [word_w-1:0] a,
                                                  logic [word_w-1:0] b);
    longint sa;
    longint sb;
    if (signed_op) begin
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        return sa * sb;
    end
    return {32'h0, a} * {32'h0, b};
endfunction

// truncating divide, remainder follows the dividend, zero divisor defined.
function automatic void ref_div(input logic signed_op, input logic [word_w-1:0] a,
                                input logic [word_w-1:0] b, output logic [word_w-1:0] q,
                                output logic [word_w-1:0] r);
    longint sa;
    longint sb;
    longint lq;
    longint lr;
    if (b == '0) begin
        q = '1;
        r = a;
    end else if (signed_op) begin
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        lq = sa / sb;   // 64-bit keeps min / -1 defined.
        lr = sa % sb;
        q  = lq[word_w-1:0];
        r  = lr[word_w-1:0];
    end else begin
        q = a / b;
        r = a % b;
    end
endfunction

task automatic check_word(string what, logic [word_w-1:0] got, logic [word_w-1:0] exp);
    checks++;
    assert (got === exp) else begin
        $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, exp);
        errors++;
    end
endtask

task automatic check_flag(string what, logic got, logic exp);
    checks++;
    assert (got === exp) else begin
        $display("MISMATCH at %0t: %s, got %b, expected %b", $time, what, got, exp);
        errors++;
    end
endtask

task automatic report_test(string name, int errs_at_start);
    if (errors == errs_at_start) begin
        $display("test %s: ok", name);
    end else begin
        $display("test %s: %0d errors", name, errors - errs_at_start);
    end
endtask

task automatic drive_op(alu_sel_e sel, logic [word_w-1:0] a, logic [word_w-1:0] b);
    @(negedge clk);
    alu_sel = sel;
    src_a   = a;
    src_b   = b;
endtask

task automatic test_reset();
    int errs_at_start;
    errs_at_start = errors;
    #(clk_period / 4);
    check_flag("stall after reset", stall, 1'b0);
    check_word("hi after reset", hi, '0);
    check_word("lo after reset", lo, '0);
    report_test("reset", errs_at_start);
endtask

task automatic run_single(alu_sel_e sel, logic [word_w-1:0] a, logic [word_w-1:0] b);
    drive_op(sel, a, b);
    #(clk_period / 4);   // combinational, checked mid-cycle.
    check_word($sformatf("%s a=%h b=%h", sel.name(), a, b), alu_res, ref_alu(sel, a, b));
endtask

task automatic test_alu_ops();
    alu_sel_e          ops [12];
    logic [word_w-1:0] edge_a [n_edge];
    logic [word_w-1:0] edge_b [n_edge];
    logic [word_w-1:0] ra;
    logic [word_w-1:0] rb;
    int                k;
    int                errs_at_start;
    ops = '{alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_nor,
            alu_or, alu_xor, alu_sll, alu_sra, alu_srl, alu_lui};
    edge_a = '{32'h0000_0000, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};
    edge_b = '{32'h0000_0001, 32'h8000_0000, 32'h0000_001f, 32'hffff_ffff};
    errs_at_start = errors;
    foreach (ops[i]) begin
        for (k = 0; k < n_edge; k++) begin
            run_single(ops[i], edge_a[k], edge_b[k]);
        end
        for (k = 0; k < n_rand; k++) begin
            ra = $random(seed);
            rb = $random(seed);
            run_single(ops[i], ra, rb);
        end
    end
    report_test("single-cycle ops", errs_at_start);
endtask

task automatic run_mult(alu_sel_e sel, logic [word_w-1:0] a, logic [word_w-1:0] b);
    logic [2*word_w-1:0] exp;
    exp = ref_mult(sel == alu_mult, a, b);
    drive_op(sel, a, b);
    @(negedge clk);   // hi/lo written at the edge in between.
    check_word($sformatf("%s hi a=%h b=%h", sel.name(), a, b), hi, exp[2*word_w-1:word_w]);
    check_word($sformatf("%s lo a=%h b=%h", sel.name(), a, b), lo, exp[word_w-1:0]);
endtask

task automatic test_mult();
    logic [word_w-1:0] ra;
    logic [word_w-1:0] rb;
    int                k;
    int                errs_at_start;
    errs_at_start = errors;
    for (k = 0; k < 2; k++) begin
        run_mult(k == 0 ? alu_mult : alu_multu, 32'hffff_fffd, 32'hffff_fffb);  // -3 * -5.
        run_mult(k == 0 ? alu_mult : alu_multu, 32'h8000_0000, 32'h8000_0000);
        run_mult(k == 0 ? alu_mult : alu_multu, 32'h8000_0000, 32'hffff_ffff);
    end
    for (k = 0; k < n_rand; k++) begin
        ra = $random(seed);
        rb = $random(seed);
        run_mult(alu_mult, ra, rb);
        run_mult(alu_multu, ra, rb);
    end
    report_test("multiply", errs_at_start);
endtask

task automatic run_div(alu_sel_e sel, logic [word_w-1:0] a, logic [word_w-1:0] b);
    logic [word_w-1:0] exp_q;
    logic [word_w-1:0] exp_r;
    int                stall_cycles;
    ref_div(sel == alu_div, a, b, exp_q, exp_r);
    drive_op(sel, a, b);
    #(clk_period / 4);
    check_flag($sformatf("%s stall at start a=%h b=%h", sel.name(), a, b), stall, 1'b1);
    stall_cycles = 0;
    while (stall === 1'b1 && stall_cycles <= div_iters + 4) begin
        stall_cycles++;
        @(negedge clk);
        #(clk_period / 4);
    end
    check_word($sformatf("%s stall cycles a=%h b=%h", sel.name(), a, b),
               stall_cycles, div_iters + 1);
    @(negedge clk);   // ready cycle has ended, hi/lo updated.
    check_word($sformatf("%s quotient a=%h b=%h", sel.name(), a, b), lo, exp_q);
    check_word($sformatf("%s remainder a=%h b=%h", sel.name(), a, b), hi, exp_r);
    alu_sel = alu_nop;   // divider ignores en for one cycle after ready.
endtask

task automatic test_div();
    logic [word_w-1:0] div_a [6];
    logic [word_w-1:0] div_b [6];
    int                errs_at_start;
    // 100/7, -100/7, 100/-7, -100/-7, min/-1, all ones / 3.
    div_a = '{32'd100, 32'hffff_ff9c, 32'd100, 32'hffff_ff9c, 32'h8000_0000, 32'hffff_ffff};
    div_b = '{32'd7, 32'd7, 32'hffff_fff9, 32'hffff_fff9, 32'hffff_ffff, 32'd3};
    errs_at_start = errors;
    foreach (div_a[i]) begin
        run_div(alu_div, div_a[i], div_b[i]);
        run_div(alu_divu, div_a[i], div_b[i]);
    end
    report_test("divide", errs_at_start);
endtask

task automatic test_div_zero();
    int errs_at_start;
    errs_at_start = errors;
    run_div(alu_div, 32'd12345, 32'd0);
    run_div(alu_divu, 32'd12345, 32'd0);
    run_div(alu_div, 32'hffff_fff9, 32'd0);
    run_div(alu_divu, 32'hffff_fff9, 32'd0);
    report_test("divide by zero", errs_at_start);
endtask

task automatic test_hilo();
    logic [word_w-1:0] x;
    logic [word_w-1:0] y;
    logic [word_w-1:0] z;
    int                errs_at_start;
    errs_at_start = errors;
    x = $random(seed);
    y = $random(seed);
    z = ~y;
    drive_op(alu_mtlo, y, x);
    @(negedge clk);
    check_word("mtlo lo", lo, y);
    drive_op(alu_mthi, x, z);
    @(negedge clk);
    check_word("mthi hi", hi, x);
    check_word("mthi leaves lo", lo, y);
    drive_op(alu_mtlo, z, y);
    @(negedge clk);
    check_word("mtlo lo", lo, z);
    check_word("mtlo leaves hi", hi, x);
    drive_op(alu_mfhi, y, z);
    #(clk_period / 4);
    check_word("mfhi result", alu_res, x);
    drive_op(alu_mflo, x, y);
    #(clk_period / 4);
    check_word("mflo result", alu_res, z);
    report_test("hi/lo moves", errs_at_start);
endtask

`endif

/* verif/tb_mips_ex.sv */
`timescale 1ns/1ps

module tb_mips_ex import ex_pkg::*; ();

    localparam int clk_period = 100;
    localparam int n_edge     = 4;    // edge operand pairs per single-cycle op.
    localparam int n_rand     = 8;    // random operand pairs per op.
    localparam int n_divs     = 16;

    // reset, single-cycle ops, multiplies and hi/lo moves, in cycles.
    localparam int n_other_ops = 6 + 12 * (n_edge + n_rand) + 2 * (3 + n_rand) + 8;
    localparam longint watchdog_ns =
        2 * (n_divs * (div_iters + 4) + n_other_ops) * clk_period;

    logic              clk;
    logic              reset;
    logic [word_w-1:0] src_a;
    logic [word_w-1:0] src_b;
    alu_sel_e          alu_sel;
    logic [word_w-1:0] alu_res;
    logic [word_w-1:0] hi;
    logic [word_w-1:0] lo;
    logic              stall;

    int seed;
    int checks;
    int errors;

    mips_ex mips_ex_i (
        .clk     (clk),
        .reset   (reset),
        .src_a   (src_a),
        .src_b   (src_b),
        .alu_sel (alu_sel),
        .alu_res (alu_res),
        .hi      (hi),
        .lo      (lo),
        .stall   (stall)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: tests still running after %0d clock periods",
                 watchdog_ns / clk_period);
        $display("CHECKS FAILED");
        $finish;
    end

`include "tb_tasks.svh"

    initial begin
        seed    = 51853;
        checks  = 0;
        errors  = 0;
        reset   = 1'b1;
        src_a   = 32'h1234_5678;
        src_b   = 32'h9abc_def1;
        alu_sel = alu_mult;   // a multiply during reset must not reach hi/lo.

        repeat (5) @(posedge clk);
        @(negedge clk);
        reset   = 1'b0;
        alu_sel = alu_nop;

        test_reset();
        test_alu_ops();
        test_mult();
        test_div();
        test_div_zero();
        test_hilo();

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* hw/mips_ex.sv */
`timescale 1ns/1ps

module mips_ex import ex_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic [word_w-1:0] src_a,
    input  logic [word_w-1:0] src_b,
    input  alu_sel_e          alu_sel,
    output logic [word_w-1:0] alu_res,
    output logic [word_w-1:0] hi,
    output logic [word_w-1:0] lo,
    output logic              stall
);
    logic              hi_we;
    logic              lo_we;
    logic [word_w-1:0] hi_next;
    logic [word_w-1:0] lo_next;

    div_if dif_i (
        .clk (clk)
    );

    alu alu_i (
        .src_a   (src_a),
        .src_b   (src_b),
        .alu_sel (alu_sel),
        .hi      (hi),
        .lo      (lo),
        .alu_res (alu_res),
        .hi_we   (hi_we),
        .lo_we   (lo_we),
        .hi_next (hi_next),
        .lo_next (lo_next),
        .dif     (dif_i.alu_side)
    );

    divider divider_i (
        .clk   (clk),
        .reset (reset),
        .dif   (dif_i.div_side)
    );

    hilo_regs hilo_regs_i (
        .clk     (clk),
        .reset   (reset),
        .hi_we   (hi_we),
        .lo_we   (lo_we),
        .hi_next (hi_next),
        .lo_next (lo_next),
        .hi      (hi),
        .lo      (lo)
    );

    assign stall = dif_i.stall;   // only the divider stalls the pipe.

endmodule

/* hw/hilo_regs.sv */
`timescale 1ns/1ps

module hilo_regs import ex_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              hi_we,
    input  logic              lo_we,
    input  logic [word_w-1:0] hi_next,
    input  logic [word_w-1:0] lo_next,
    output logic [word_w-1:0] hi,
    output logic [word_w-1:0] lo
);
    // architectural hi, remainder or upper product half.
    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
        end else if (hi_we) begin
            hi <= hi_next;
        end
    end

    // architectural lo, quotient or lower product half.
    always_ff @(posedge clk) begin
        if (reset) begin
            lo <= '0;
        end else if (lo_we) begin
            lo <= lo_next;
        end
    end

endmodule

/* hw/alu.sv */
`timescale 1ns/1ps

module alu import ex_pkg::*; (
    input  logic [word_w-1:0] src_a,
    input  logic [word_w-1:0] src_b,
    input  alu_sel_e          alu_sel,
    input  logic [word_w-1:0] hi,
    input  logic [word_w-1:0] lo,
    output logic [word_w-1:0] alu_res,
    output logic              hi_we,
    output logic              lo_we,
    output logic [word_w-1:0] hi_next,
    output logic [word_w-1:0] lo_next,
    div_if.alu_side           dif
);
    logic [2*word_w-1:0]         s_prod;
    logic [2*word_w-1:0]         u_prod;
    logic [$clog2(word_w)-1:0]   shamt;
    logic [word_w-1:0]           sll_val;
    logic [word_w-1:0]           sra_val;
    logic [word_w-1:0]           srl_val;
    logic                        lt_s;
    logic                        lt_u;

    // full 64-bit products, operands extended first.
    assign s_prod = $signed({{word_w{src_a[word_w-1]}}, src_a}) *
                    $signed({{word_w{src_b[word_w-1]}}, src_b});
    assign u_prod = {{word_w{1'b0}}, src_a} * {{word_w{1'b0}}, src_b};

    assign shamt   = src_b[$clog2(word_w)-1:0];
    assign sll_val = src_a << shamt;
    assign sra_val = $signed(src_a) >>> shamt;
    assign srl_val = src_a >> shamt;
    assign lt_s    = $signed(src_a) < $signed(src_b);
    assign lt_u    = src_a < src_b;

    // divider always sees the current operands.
    assign dif.dividend = src_a;
    assign dif.divisor  = src_b;

    always_comb begin
        alu_res  = '0;
        hi_we    = 1'b0;
        lo_we    = 1'b0;
        hi_next  = '0;
        lo_next  = '0;
        dif.en   = 1'b0;
        dif.sign = 1'b0;

        case (alu_sel)
            alu_add:  alu_res = src_a + src_b;   // wraps, no trap.
            alu_sub:  alu_res = src_a - src_b;
            alu_slt:  alu_res = {{(word_w-1){1'b0}}, lt_s};
            alu_sltu: alu_res = {{(word_w-1){1'b0}}, lt_u};
            alu_div, alu_divu: begin
                dif.en   = 1'b1;
                dif.sign = (alu_sel == alu_div);
                hi_we    = dif.ready;
                lo_we    = dif.ready;
                hi_next  = dif.remainder;
                lo_next  = dif.quotient;
            end
            alu_mult: begin
                hi_we   = 1'b1;
                lo_we   = 1'b1;
                hi_next = s_prod[2*word_w-1:word_w];
                lo_next = s_prod[word_w-1:0];
            end
            alu_multu: begin
                hi_we   = 1'b1;
                lo_we   = 1'b1;
                hi_next = u_prod[2*word_w-1:word_w];
                lo_next = u_prod[word_w-1:0];
            end
            alu_and:  alu_res = src_a & src_b;
            alu_nor:  alu_res = ~(src_a | src_b);
            alu_or:   alu_res = src_a | src_b;
            alu_xor:  alu_res = src_a ^ src_b;
            alu_sll:  alu_res = sll_val;
            alu_sra:  alu_res = sra_val;
            alu_srl:  alu_res = srl_val;
            alu_lui:  alu_res = {src_b[word_w/2-1:0], {(word_w/2){1'b0}}};
            alu_mthi: begin
                hi_we   = 1'b1;
                hi_next = src_a;
            end
            alu_mtlo: begin
                lo_we   = 1'b1;
                lo_next = src_a;
            end
            alu_mfhi: alu_res = hi;   // value from before the edge.
            alu_mflo: alu_res = lo;
            default:  alu_res = '0;
        endcase
    end

    // pipeline must hold the instruction through the ready cycle.
    a_ops_held: assert property (@(posedge dif.clk)
        dif.stall |=> $stable(src_a) && $stable(src_b) && $stable(alu_sel))
        else $error("alu: inputs changed during a divide stall");

endmodule

/* hw/divider.sv */
`timescale 1ns/1ps

module divider import ex_pkg::*; (
    input logic     clk,
    input logic     reset,
    div_if.div_side dif
);
    typedef enum logic [1:0] {
        div_idle,
        div_busy,
        div_done,
        div_hold
    } div_state_e;

    div_state_e state;
    logic [div_cnt_w-1:0] cnt;

    logic [word_w-1:0] rem_q;
    logic [word_w-1:0] quo_q;   // dividend bits shift out, quotient bits shift in.
    logic [word_w-1:0] dvs_q;
    logic              q_neg;
    logic              r_neg;
    logic              dvz;

    logic              start;
    logic              a_neg;
    logic              b_neg;
    logic [word_w-1:0] a_mag;
    logic [word_w-1:0] b_mag;
    logic [word_w:0]   partial;
    logic [word_w:0]   diff;

    assign start = (state == div_idle) && dif.en;

    // magnitudes of the operands, signed only for div.
    assign a_neg = dif.sign && dif.dividend[word_w-1];
    assign b_neg = dif.sign && dif.divisor[word_w-1];
    assign a_mag = a_neg ? -dif.dividend : dif.dividend;
    assign b_mag = b_neg ? -dif.divisor : dif.divisor;

    // one restoring step.
    assign partial = {rem_q, quo_q[word_w-1]};
    assign diff    = partial - {1'b0, dvs_q};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= div_idle;
            cnt   <= '0;
        end else begin
            case (state)
                div_idle: begin
                    if (start) begin
                        state <= div_busy;
                        cnt   <= '0;
                    end
                end
                div_busy: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == div_cnt_w'(div_iters - 1)) begin
                        state <= div_done;
                    end
                end
                div_done: state <= div_hold;   // en is ignored for one cycle.
                default:  state <= div_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rem_q <= '0;
            quo_q <= a_mag;
            dvs_q <= b_mag;
            q_neg <= a_neg ^ b_neg;
            r_neg <= a_neg;                  // remainder follows the dividend.
            dvz   <= (dif.divisor == '0);
        end else if (state == div_busy) begin
            if (!diff[word_w]) begin
                rem_q <= diff[word_w-1:0];
                quo_q <= {quo_q[word_w-2:0], 1'b1};
            end else begin
                rem_q <= partial[word_w-1:0];
                quo_q <= {quo_q[word_w-2:0], 1'b0};
            end
        end
    end

    // sign fix on the way out; a zero divisor leaves rem_q at |dividend|.
    assign dif.quotient  = dvz ? '1 : (q_neg ? -quo_q : quo_q);
    assign dif.remainder = r_neg ? -rem_q : rem_q;
    assign dif.ready     = (state == div_done);
    assign dif.stall     = start || (state == div_busy);

    // result due div_iters + 1 cycles after the start.
    a_ready_pulse: assert property (@(posedge clk) disable iff (reset)
        start |-> ##(div_iters + 1) dif.ready ##1 !dif.ready)
        else $error("divider: ready not a single pulse div_iters + 1 cycles after start");

    a_stall_ready: assert property (@(posedge clk) disable iff (reset)
        start |-> ##(div_iters + 1) !dif.stall)
        else $error("divider: stall still high in the ready cycle");

    // the request may not move between the start and the result.
    a_ops_stable: assert property (@(posedge clk) disable iff (reset)
        (state == div_busy || state == div_done) |->
            $stable(dif.dividend) && $stable(dif.divisor) && $stable(dif.sign))
        else $error("divider: operands changed while busy");

endmodule

/* hw/div_if.sv */
`timescale 1ns/1ps

interface div_if import ex_pkg::*; (
    input logic clk
);
    // request, held by the alu while the selector is div or divu.
    logic              en;
    logic              sign;
    logic [word_w-1:0] dividend;
    logic [word_w-1:0] divisor;

    // result side.
    logic [word_w-1:0] quotient;
    logic [word_w-1:0] remainder;
    logic              ready;   // one cycle pulse.
    logic              stall;   // low again in the ready cycle.

    // clk is only seen by the alu side, for its hold check.
    modport alu_side (
        input  clk,
        output en, sign, dividend, divisor,
        input  quotient, remainder, ready, stall
    );

    modport div_side (
        input  en, sign, dividend, divisor,
        output quotient, remainder, ready, stall
    );

endinterface

/* hw/ex_pkg.sv */
package ex_pkg;

    // datapath word.
    localparam int word_w = 32;

    // divider loop, one quotient bit per cycle.
    localparam int div_iters = 32;
    localparam int div_cnt_w = 6;   // holds 0 .. div_iters-1.

    // operation selector driven by decode.
    typedef enum logic [5:0] {
        alu_nop   = 6'd0,
        alu_add   = 6'd1,
        alu_sub   = 6'd2,
        alu_slt   = 6'd3,
        alu_sltu  = 6'd4,
        alu_div   = 6'd5,
        alu_divu  = 6'd6,
        alu_mult  = 6'd7,
        alu_multu = 6'd8,
        alu_and   = 6'd9,
        alu_nor   = 6'd10,
        alu_or    = 6'd11,
        alu_xor   = 6'd12,
        alu_sll   = 6'd13,
        alu_sra   = 6'd14,
        alu_srl   = 6'd15,
        alu_lui   = 6'd16,
        alu_mthi  = 6'd17,
        alu_mtlo  = 6'd18,
        alu_mfhi  = 6'd19,
        alu_mflo  = 6'd20
    } alu_sel_e;

endpackage
